//--- Bender.yml
package:
  name: ldx_path

sources:
  - hdl/memOpPkg.sv
  - hdl/lsqPkg.sv
  - hdl/stqSearchIf.sv
  - hdl/stqCam.sv
  - hdl/storeQueue.sv
  - hdl/loadQueue.sv
  - hdl/loadDisambig.sv
  - hdl/loadMemPort.sv
  - hdl/ldxPath.sv
  - target: simulation
    files:
      - dv/tb_ldxPath.sv

//--- dv/tb_ldxPath.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// load execution path testbench
// store order, forwarding, violations, memory reads
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_ldxPath
	import memOpPkg::*, lsqPkg::*;
();

	localparam logic [31:0] Seed = 32'hcb11015c;
	localparam addrT MemBase = 32'h0004_2000;
	localparam int KindMem = 0;
	localparam int KindFwd = 1;
	localparam int KindViol = 2;
	// worst case a few cycles per store op, one bus read per load
	localparam int TotalStores = 18 + 12 + 6 + 4;
	localparam int TotalLoads = 6 + 8 + 6 + 4;
	localparam int CycleLimit = 100 + 8 * TotalStores + 16 * TotalLoads;

	logic clk;
	logic reset;
	logic recover_i;
	logic stDispatch_i;
	stqIdxT stqId_o;
	logic stqFull_o;
	logic ldDispatch_i;
	ldqIdxT ldDispatchIdx_i;
	logic stAgenValid_i;
	stqIdxT stAgenIdx_i;
	addrT stAgenAddr_i;
	dataT stAgenData_i;
	accessSizeT stAgenSize_i;
	logic commitSt_i;
	logic stCommitValid_o;
	addrT stCommitAddr_o;
	dataT stCommitData_o;
	accessSizeT stCommitSize_o;
	logic ldIssue_i;
	ldqIdxT ldIdx_i;
	addrT ldAddr_i;
	accessSizeT ldSize_i;
	logic ldReady_o;
	logic loadValid_o;
	dataT loadData_o;
	logic ldViolation_o;
	ldqIdxT ldViolIdx_o;
	logic wbCyc_o;
	logic wbStb_o;
	logic wbWe_o;
	addrT wbAdr_o;
	selT wbSel_o;
	dataT wbDat_i;
	logic wbAck_i;

	// reference store queue and load records
	addrT modelAddr [StqDepth];
	dataT modelData [StqDepth];
	accessSizeT modelSize [StqDepth];
	logic modelAgen [StqDepth];
	stqIdxT modelHead;
	stqIdxT modelTail;
	int modelCount;
	stqIdxT recLast [LdqDepth];
	logic recValid [LdqDepth];
	stqIdxT stIds [StqDepth];

	// memory model, 64 words above MemBase
	dataT memWords [64];
	logic memWritten [64];
	logic [31:0] ackRng;
	int ackWait;
	logic ackArmed;
	int ackCount;

	// outstanding load expectations
	int expKindQ [$];
	dataT expDataQ [$];
	ldqIdxT expIdxQ [$];
	int issuedCount;
	int resultsSeen;
	int memDone;
	logic sawCyc;
	int gotKind;
	dataT gotData;
	ldqIdxT gotIdx;

	logic [31:0] rngState;
	int checkCount;
	int errorCount;
	int testCheckBase;
	int testErrorBase;
	int cycleCount;

	ldxPath uut (.*);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount > CycleLimit)
		begin
			$display("timeout: run exceeded %0d cycles without finishing", CycleLimit);
			$display("Simulation failed");
			$finish;
		end
	end

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	// one step per bit taken
	function automatic logic [31:0] drawBits(input int count);
		logic [31:0] value;
		value = '0;
		for (int b = 0; b < count; b++)
		begin
			rngState = lfsrNext(rngState);
			value = {value[30:0], rngState[0]};
		end
		return value;
	endfunction

	function automatic dataT sizeMask(input accessSizeT size);
		case (size)
			SizeByte: return 32'h0000_00ff;
			SizeHalf: return 32'h0000_ffff;
			default: return 32'hffff_ffff;
		endcase
	endfunction

	// byte lanes the access covers
	function automatic selT laneMask(input addrT addr, input accessSizeT size);
		selT lanes;
		lanes = '0;
		for (int b = 0; b < (1 << size); b++)
		begin
			lanes[addr[1:0] + b] = 1'b1;
		end
		return lanes;
	endfunction

	// unwritten words follow the full word address
	function automatic dataT memWord(input addrT addr);
		if (memWritten[addr[7:2]])
		begin
			return memWords[addr[7:2]];
		end
		return (dataT'(addr[31:2]) * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
	endfunction

	function automatic addrT makeAddr(input logic [5:0] wordIdx, input offsetT offset);
		return MemBase | addrT'({wordIdx, offset});
	endfunction

	// naturally aligned for the size
	function automatic addrT randomAddr(input accessSizeT size);
		logic [5:0] wordIdx;
		offsetT offset;
		wordIdx = 6'(drawBits(6));
		case (size)
			SizeByte: offset = offsetT'(drawBits(2));
			SizeHalf: offset = {drawBits(1) != 0, 1'b0};
			default: offset = 2'd0;
		endcase
		return makeAddr(wordIdx, offset);
	endfunction

	// expected outcome of a load from the older stores it may see
	function automatic int predictLoad(input addrT addr, input accessSizeT size,
		input stqIdxT lastIdx, input logic lastValid, output dataT result);
		int span;
		stqIdxT idx;
		logic partial;
		logic hit;
		dataT fwd;
		partial = 1'b0;
		hit = 1'b0;
		fwd = '0;
		span = lastValid ? int'(stqIdxT'(lastIdx - modelHead)) + 1 : 0;
		for (int k = 0; k < span; k++)
		begin
			idx = modelHead + stqIdxT'(k);
			if (modelAgen[idx] && modelAddr[idx][31:2] == addr[31:2])
			begin
				if (modelAddr[idx][1:0] == addr[1:0] && modelSize[idx] >= size)
				begin
					// oldest first, so the last hit is the youngest
					hit = 1'b1;
					fwd = modelData[idx] & sizeMask(size);
				end
				else
				begin
					partial = 1'b1;
				end
			end
		end
		result = (memWord(addr) >> {addr[1:0], 3'b000}) & sizeMask(size);
		if (partial)
		begin
			return KindViol;
		end
		if (hit)
		begin
			result = fwd;
			return KindFwd;
		end
		return KindMem;
	endfunction

	task automatic checkValue(input string name, input dataT got, input dataT exp);
		checkCount++;
		assert (got === exp)
		else
		begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			errorCount++;
		end
	endtask

	task automatic checkTrue(input logic cond, input string what);
		checkCount++;
		assert (cond)
		else
		begin
			$display("%s", what);
			errorCount++;
		end
	endtask

	task automatic applyStore(input addrT addr, input dataT data, input accessSizeT size);
		dataT word;
		word = memWord(addr);
		for (int b = 0; b < (1 << size); b++)
		begin
			word[(addr[1:0] + b) * 8 +: 8] = data[b * 8 +: 8];
		end
		memWords[addr[7:2]] = word;
		memWritten[addr[7:2]] = 1'b1;
	endtask

	task automatic dispatchStore(output stqIdxT idx);
		checkValue("stqId_o", stqId_o, modelTail);
		checkValue("stqFull_o", stqFull_o, 1'b0);
		idx = modelTail;
		stDispatch_i = 1'b1;
		@(negedge clk);
		stDispatch_i = 1'b0;
		modelAgen[idx] = 1'b0;
		modelTail++;
		modelCount++;
	endtask

	task automatic agenStore(input stqIdxT idx, input addrT addr, input dataT data,
		input accessSizeT size);
		stAgenValid_i = 1'b1;
		stAgenIdx_i = idx;
		stAgenAddr_i = addr;
		stAgenData_i = data;
		stAgenSize_i = size;
		@(negedge clk);
		stAgenValid_i = 1'b0;
		modelAddr[idx] = addr;
		modelData[idx] = data;
		modelSize[idx] = size;
		modelAgen[idx] = 1'b1;
	endtask

	task automatic storeOp(input addrT addr, input dataT data, input accessSizeT size);
		stqIdxT idx;
		dispatchStore(idx);
		agenStore(idx, addr, data, size);
	endtask

	task automatic commitStore();
		checkValue("stCommitValid_o", stCommitValid_o, 1'b1);
		checkValue("stCommitAddr_o", stCommitAddr_o, modelAddr[modelHead]);
		checkValue("stCommitData_o", stCommitData_o, modelData[modelHead]);
		checkValue("stCommitSize_o", stCommitSize_o, modelSize[modelHead]);
		commitSt_i = 1'b1;
		@(negedge clk);
		commitSt_i = 1'b0;
		applyStore(modelAddr[modelHead], modelData[modelHead], modelSize[modelHead]);
		// loads waiting on this store see no older store now
		for (int i = 0; i < LdqDepth; i++)
		begin
			if (recLast[i] == modelHead)
			begin
				recValid[i] = 1'b0;
			end
		end
		modelAgen[modelHead] = 1'b0;
		modelHead++;
		modelCount--;
	endtask

	task automatic dispatchLoad(input ldqIdxT idx);
		recLast[idx] = modelTail - 1'b1;
		recValid[idx] = (modelCount != 0);
		ldDispatch_i = 1'b1;
		ldDispatchIdx_i = idx;
		@(negedge clk);
		ldDispatch_i = 1'b0;
	endtask

	task automatic issueLoad(input ldqIdxT idx, input addrT addr, input accessSizeT size);
		int kind;
		dataT expData;
		while (!ldReady_o)
		begin
			@(negedge clk);
		end
		kind = predictLoad(addr, size, recLast[idx], recValid[idx], expData);
		expKindQ.push_back(kind);
		expDataQ.push_back(expData);
		expIdxQ.push_back(idx);
		issuedCount++;
		ldIssue_i = 1'b1;
		ldIdx_i = idx;
		ldAddr_i = addr;
		ldSize_i = size;
		@(negedge clk);
		ldIssue_i = 1'b0;
		// checker signals completion
		while (resultsSeen < issuedCount)
		begin
			@(negedge clk);
		end
	endtask

	task automatic loadOp(input addrT addr, input accessSizeT size);
		ldqIdxT idx;
		idx = ldqIdxT'(drawBits(3));
		dispatchLoad(idx);
		issueLoad(idx, addr, size);
	endtask

	task automatic recoverQueues();
		recover_i = 1'b1;
		@(negedge clk);
		recover_i = 1'b0;
		modelTail = modelHead;
		modelCount = 0;
		for (int i = 0; i < StqDepth; i++)
		begin
			modelAgen[i] = 1'b0;
			recValid[i] = 1'b0;
		end
	endtask

	task automatic beginTest();
		testCheckBase = checkCount;
		testErrorBase = errorCount;
	endtask

	task automatic reportTest(input int number, input string name);
		$display("test %0d %s: %0d checks, %0d errors", number, name,
			checkCount - testCheckBase, errorCount - testErrorBase);
	endtask

	// wishbone slave with 0 to 3 cycles of ack delay
	always @(negedge clk)
	begin
		if (reset)
		begin
			wbAck_i = 1'b0;
			ackArmed = 1'b0;
		end
		else if (wbAck_i)
		begin
			wbAck_i = 1'b0;
		end
		else if (wbCyc_o && wbStb_o)
		begin
			if (!ackArmed)
			begin
				ackArmed = 1'b1;
				ackRng = lfsrNext(ackRng);
				ackWait = ackRng[0];
				ackRng = lfsrNext(ackRng);
				ackWait = ackWait + 2 * ackRng[0];
			end
			if (ackWait == 0)
			begin
				checkTrue(!wbWe_o, "write cycle seen on the load read bus");
				// request carries the issued load's address and lanes
				checkValue("wbAdr_o", wbAdr_o, ldAddr_i);
				checkValue("wbSel_o", wbSel_o, laneMask(ldAddr_i, ldSize_i));
				wbDat_i = memWord(wbAdr_o);
				wbAck_i = 1'b1;
				ackArmed = 1'b0;
				ackCount++;
			end
			else
			begin
				ackWait--;
			end
		end
	end

	// result checker
	always @(negedge clk)
	begin
		if (!reset)
		begin
			if (wbCyc_o)
			begin
				sawCyc = 1'b1;
			end
			if (loadValid_o || ldViolation_o)
			begin
				if (expKindQ.size() == 0)
				begin
					checkTrue(1'b0, "load result arrived with no load outstanding");
				end
				else
				begin
					gotKind = expKindQ.pop_front();
					gotData = expDataQ.pop_front();
					gotIdx = expIdxQ.pop_front();
					checkValue("ldViolation_o", ldViolation_o, gotKind == KindViol);
					checkValue("loadValid_o", loadValid_o, gotKind != KindViol);
					if (gotKind == KindViol)
					begin
						checkValue("ldViolIdx_o", ldViolIdx_o, gotIdx);
					end
					else
					begin
						checkValue("loadData_o", loadData_o, gotData);
					end
					checkValue("wbCyc_o seen", sawCyc, gotKind == KindMem);
					if (gotKind == KindMem)
					begin
						// result must follow its ack
						memDone++;
						checkValue("wbAck_i count", ackCount, memDone);
					end
				end
				sawCyc = 1'b0;
				resultsSeen++;
			end
		end
	end

	initial
	begin
		int n;
		logic [5:0] wordIdx;
		accessSizeT size;
		addrT addr;
		dataT data;
		ldqIdxT ldIdx;
		reset = 1'b1;
		recover_i = 1'b0;
		stDispatch_i = 1'b0;
		ldDispatch_i = 1'b0;
		ldDispatchIdx_i = '0;
		stAgenValid_i = 1'b0;
		stAgenIdx_i = '0;
		stAgenAddr_i = '0;
		stAgenData_i = '0;
		stAgenSize_i = SizeByte;
		commitSt_i = 1'b0;
		ldIssue_i = 1'b0;
		ldIdx_i = '0;
		ldAddr_i = '0;
		ldSize_i = SizeByte;
		wbDat_i = '0;
		wbAck_i = 1'b0;
		sawCyc = 1'b0;
		rngState = Seed;
		ackRng = Seed;
		modelHead = '0;
		modelTail = '0;
		modelCount = 0;
		for (int i = 0; i < 64; i++)
		begin
			memWritten[i] = 1'b0;
		end
		for (int i = 0; i < StqDepth; i++)
		begin
			modelAgen[i] = 1'b0;
			recValid[i] = 1'b0;
		end
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// outputs at reset values, ready held off one cycle
		beginTest();
		checkValue("ldReady_o", ldReady_o, 1'b0);
		checkValue("loadValid_o", loadValid_o, 1'b0);
		checkValue("ldViolation_o", ldViolation_o, 1'b0);
		checkValue("wbCyc_o", wbCyc_o, 1'b0);
		checkValue("wbStb_o", wbStb_o, 1'b0);
		checkValue("stCommitValid_o", stCommitValid_o, 1'b0);
		@(negedge clk);
		checkValue("ldReady_o", ldReady_o, 1'b1);

		// fill to full once, wrap past the end
		for (int r = 0; r < 3; r++)
		begin
			n = (r == 1) ? StqDepth : 4 + r;
			for (int i = 0; i < n; i++)
			begin
				dispatchStore(stIds[i]);
			end
			checkValue("stqFull_o", stqFull_o, n == StqDepth);
			// agen youngest first, commit still in order
			for (int i = n - 1; i >= 0; i--)
			begin
				size = accessSizeT'(drawBits(2) % 3);
				addr = randomAddr(size);
				data = drawBits(32);
				agenStore(stIds[i], addr, data, size);
			end
			repeat (n) commitStore();
			checkValue("stCommitValid_o", stCommitValid_o, 1'b0);
		end
		reportTest(1, "store dispatch and commit");

		beginTest();
		for (int i = 0; i < 6; i++)
		begin
			size = accessSizeT'(drawBits(2) % 3);
			loadOp(randomAddr(size), size);
		end
		reportTest(2, "memory read");

		beginTest();
		for (int i = 0; i < 4; i++)
		begin
			wordIdx = 6'(drawBits(6));
			size = (drawBits(1) != 0) ? SizeHalf : SizeByte;
			storeOp(makeAddr(wordIdx, 2'd0), drawBits(32), SizeWord);
			storeOp(makeAddr(wordIdx ^ 6'd1, 2'd0), drawBits(32), SizeWord);
			storeOp(makeAddr(wordIdx, 2'd0), drawBits(32), SizeHalf);
			loadOp(makeAddr(wordIdx, 2'd0), size);
			loadOp(makeAddr(wordIdx ^ 6'd1, 2'd0), SizeWord);
			repeat (3) commitStore();
		end
		reportTest(3, "store forwarding");

		beginTest();
		for (int i = 0; i < 3; i++)
		begin
			wordIdx = 6'(drawBits(6));
			// offset 1 or 3 against a word store at 0
			storeOp(makeAddr(wordIdx, 2'd0), drawBits(32), SizeWord);
			loadOp(makeAddr(wordIdx, offsetT'(drawBits(2) | 32'd1)), SizeByte);
			commitStore();
			// byte store under a half load
			storeOp(makeAddr(wordIdx, 2'd2), drawBits(32), SizeByte);
			loadOp(makeAddr(wordIdx, 2'd2), SizeHalf);
			commitStore();
		end
		reportTest(4, "partial overlap violation");

		beginTest();
		for (int i = 0; i < 2; i++)
		begin
			wordIdx = 6'(drawBits(6));
			storeOp(makeAddr(wordIdx, 2'd0), drawBits(32), SizeWord);
			ldIdx = ldqIdxT'(drawBits(3));
			dispatchLoad(ldIdx);
			commitStore();
			issueLoad(ldIdx, makeAddr(wordIdx, 2'd0), SizeWord);
			// flushed store never reaches memory
			storeOp(makeAddr(wordIdx, 2'd0), drawBits(32), SizeHalf);
			ldIdx = ldqIdxT'(drawBits(3));
			dispatchLoad(ldIdx);
			recoverQueues();
			issueLoad(ldIdx, makeAddr(wordIdx, 2'd0), SizeHalf);
		end
		reportTest(5, "commit and recovery");

		$display("tests 5, checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0)
		begin
			$display("Simulation passed");
		end
		else
		begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- hdl/ldxPath.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// load execution path top
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ldxPath
	import memOpPkg::*, lsqPkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       recover_i,
	input  logic       stDispatch_i,
	output stqIdxT     stqId_o,
	output logic       stqFull_o,
	input  logic       ldDispatch_i,
	input  ldqIdxT     ldDispatchIdx_i,
	input  logic       stAgenValid_i,
	input  stqIdxT     stAgenIdx_i,
	input  addrT       stAgenAddr_i,
	input  dataT       stAgenData_i,
	input  accessSizeT stAgenSize_i,
	input  logic       commitSt_i,
	output logic       stCommitValid_o,
	output addrT       stCommitAddr_o,
	output dataT       stCommitData_o,
	output accessSizeT stCommitSize_o,
	input  logic       ldIssue_i,
	input  ldqIdxT     ldIdx_i,
	input  addrT       ldAddr_i,
	input  accessSizeT ldSize_i,
	output logic       ldReady_o,
	output logic       loadValid_o,
	output dataT       loadData_o,
	output logic       ldViolation_o,
	output ldqIdxT     ldViolIdx_o,
	output logic       wbCyc_o,
	output logic       wbStb_o,
	output logic       wbWe_o,
	output addrT       wbAdr_o,
	output selT        wbSel_o,
	input  dataT       wbDat_i,
	input  logic       wbAck_i
);

	stqSearchIf stqSearch ();

	logic       stqEmpty;
	stqIdxT     lastSt;
	logic       lastStValid;
	logic       memBusy;
	logic       fwdValid;
	dataT       fwdData;
	logic       memReq;
	addrT       memAddr;
	accessSizeT memSize;

	storeQueue stq (
		.clk, .reset, .recover_i, .stDispatch_i, .stAgenValid_i, .stAgenIdx_i,
		.stAgenAddr_i, .stAgenData_i, .stAgenSize_i, .commitSt_i,
		.search          (stqSearch.store),
		.tail_o          (stqId_o),
		.empty_o         (stqEmpty),
		.full_o          (stqFull_o),
		.stCommitValid_o, .stCommitAddr_o, .stCommitData_o, .stCommitSize_o
	);

	// record looked up by the load held in disambiguation
	loadQueue ldq (
		.clk, .reset, .recover_i, .ldDispatch_i, .ldDispatchIdx_i,
		.stqTail_i       (stqId_o),
		.stqEmpty_i      (stqEmpty),
		.commitSt_i,
		.stqHead_i       (stqSearch.head),
		.ldLookupIdx_i   (ldViolIdx_o),
		.lastSt_o        (lastSt),
		.lastStValid_o   (lastStValid)
	);

	loadDisambig disambig (
		.clk, .reset, .recover_i, .ldIssue_i, .ldIdx_i, .ldAddr_i, .ldSize_i, .ldReady_o,
		.memBusy_i       (memBusy),
		.lastSt_i        (lastSt),
		.lastStValid_i   (lastStValid),
		.search          (stqSearch.searcher),
		.fwdValid_o      (fwdValid),
		.fwdData_o       (fwdData),
		.violation_o     (ldViolation_o),
		.violIdx_o       (ldViolIdx_o),
		.memReq_o        (memReq),
		.memAddr_o       (memAddr),
		.memSize_o       (memSize)
	);

	loadMemPort memPort (
		.clk, .reset,
		.req_i           (memReq),
		.addr_i          (memAddr),
		.size_i          (memSize),
		.fwdValid_i      (fwdValid),
		.fwdData_i       (fwdData),
		.busy_o          (memBusy),
		.wbCyc_o, .wbStb_o, .wbWe_o, .wbAdr_o, .wbSel_o, .wbDat_i, .wbAck_i,
		.loadValid_o, .loadData_o
	);

endmodule

//--- hdl/loadDisambig.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// load disambiguation stage
// forwarding pick, partial-match check
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module loadDisambig
	import memOpPkg::*, lsqPkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  logic         recover_i,
	input  logic         ldIssue_i,
	input  ldqIdxT       ldIdx_i,
	input  addrT         ldAddr_i,
	input  accessSizeT   ldSize_i,
	output logic         ldReady_o,
	input  logic         memBusy_i,
	input  stqIdxT       lastSt_i,
	input  logic         lastStValid_i,
	stqSearchIf.searcher search,
	output logic         fwdValid_o,
	output dataT         fwdData_o,
	output logic         violation_o,
	output ldqIdxT       violIdx_o,
	output logic         memReq_o,
	output addrT         memAddr_o,
	output accessSizeT   memSize_o
);

	logic       readyArmed;
	logic       stageValid;
	ldqIdxT     stageIdx;
	addrT       stageAddr;
	accessSizeT stageSize;
	logic       fire;
	stqVecT     span;
	stqVecT     window;
	stqVecT     fwdVec;
	stqVecT     partialVec;
	logic       fwdHit;
	logic       partialHit;
	stqIdxT     scanIdx;
	stqIdxT     youngestHit;

	// one load in flight, held off for a cycle after reset
	assign ldReady_o = readyArmed && !stageValid && !memBusy_i;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			readyArmed  <= 1'b0;
			stageValid  <= 1'b0;
			violation_o <= 1'b0;
		end
		else
		begin
			readyArmed  <= 1'b1;
			stageValid  <= ldIssue_i && ldReady_o && !recover_i;
			violation_o <= fire && partialHit;
		end
	end

	always_ff @(posedge clk)
	begin
		if (ldIssue_i && ldReady_o)
		begin
			stageIdx  <= ldIdx_i;
			stageAddr <= ldAddr_i;
			stageSize <= ldSize_i;
		end
	end

	assign fire = stageValid && !recover_i;

	// stores from head up to the youngest older one
	always_comb
	begin
		for (int i = 0; i < StqDepth; i++)
		begin
			if (lastSt_i >= search.head)
			begin
				span[i] = (i >= search.head) && (i <= lastSt_i);
			end
			else
			begin
				span[i] = (i >= search.head) || (i <= lastSt_i);
			end
		end
	end

	// only stores whose address is already known
	assign window     = lastStValid_i ? (span & search.addrValid) : '0;
	assign fwdVec     = window & search.wordMatch & search.offsetMatch & search.sizeGreater;
	assign partialVec = window & search.wordMatch & (~search.offsetMatch | ~search.sizeGreater);
	assign fwdHit     = |fwdVec;
	assign partialHit = |partialVec;

	// walk oldest to youngest, last hit wins
	always_comb
	begin
		youngestHit = search.head;
		scanIdx     = search.head;
		for (int k = 0; k < StqDepth; k++)
		begin
			scanIdx = search.head + stqIdxT'(k);
			if (fwdVec[scanIdx])
			begin
				youngestHit = scanIdx;
			end
		end
	end

	assign search.wordAddr = stageAddr[AddrWidth-1:OffsetWidth];
	assign search.offset   = stageAddr[OffsetWidth-1:0];
	assign search.size     = stageSize;
	assign search.fwdIdx   = youngestHit;

	// a partial overlap wins over any forward
	assign fwdValid_o = fire && fwdHit && !partialHit;
	assign fwdData_o  = zeroExtend(search.fwdEntry.data, stageSize);
	assign memReq_o   = fire && !fwdHit && !partialHit;
	assign memAddr_o  = stageAddr;
	assign memSize_o  = stageSize;
	assign violIdx_o  = stageIdx;

endmodule

//--- hdl/loadMemPort.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// load read master on Wishbone
// aligns and returns load results
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module loadMemPort
	import memOpPkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       req_i,
	input  addrT       addr_i,
	input  accessSizeT size_i,
	input  logic       fwdValid_i,
	input  dataT       fwdData_i,
	output logic       busy_o,
	output logic       wbCyc_o,
	output logic       wbStb_o,
	output logic       wbWe_o,
	output addrT       wbAdr_o,
	output selT        wbSel_o,
	input  dataT       wbDat_i,
	input  logic       wbAck_i,
	output logic       loadValid_o,
	output dataT       loadData_o
);

	offsetT     reqOffset;
	accessSizeT reqSize;
	selT        sel;
	dataT       aligned;

	// byte lanes touched by the access
	always_comb
	begin
		case (size_i)
			SizeByte: sel = selT'(1) << addr_i[OffsetWidth-1:0];
			SizeHalf: sel = selT'(3) << addr_i[OffsetWidth-1:0];
			default:  sel = '1;
		endcase
	end

	// reads only
	assign wbWe_o  = 1'b0;
	assign busy_o  = wbCyc_o;
	assign aligned = zeroExtend(wbDat_i >> {reqOffset, 3'b000}, reqSize);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wbCyc_o     <= 1'b0;
			wbStb_o     <= 1'b0;
			loadValid_o <= 1'b0;
		end
		else
		begin
			loadValid_o <= 1'b0;
			if (wbCyc_o)
			begin
				// cycle ends on ack, result next cycle
				if (wbAck_i)
				begin
					wbCyc_o     <= 1'b0;
					wbStb_o     <= 1'b0;
					loadValid_o <= 1'b1;
				end
			end
			else if (req_i)
			begin
				wbCyc_o <= 1'b1;
				wbStb_o <= 1'b1;
			end
			else if (fwdValid_i)
			begin
				loadValid_o <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (!wbCyc_o && req_i)
		begin
			wbAdr_o   <= addr_i;
			wbSel_o   <= sel;
			reqOffset <= addr_i[OffsetWidth-1:0];
			reqSize   <= size_i;
		end
		if (wbCyc_o && wbAck_i)
		begin
			loadData_o <= aligned;
		end
		else if (!wbCyc_o && fwdValid_i)
		begin
			loadData_o <= fwdData_i;
		end
	end

	stbHeldToAck: assert property (@(posedge clk) disable iff (reset)
		wbStb_o && !wbAck_i |=> wbStb_o && $stable(wbAdr_o));

endmodule

//--- hdl/loadQueue.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// load queue older-store record
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module loadQueue
	import lsqPkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   recover_i,
	input  logic   ldDispatch_i,
	input  ldqIdxT ldDispatchIdx_i,
	input  stqIdxT stqTail_i,
	input  logic   stqEmpty_i,
	input  logic   commitSt_i,
	input  stqIdxT stqHead_i,
	input  ldqIdxT ldLookupIdx_i,
	output stqIdxT lastSt_o,
	output logic   lastStValid_o
);

	stqIdxT              lastSt [LdqDepth];
	logic [LdqDepth-1:0] lastStValid;
	stqIdxT              youngestSt;
	logic                youngestLeaving;

	// last allocated store is the one just behind tail
	assign youngestSt      = stqTail_i - 1'b1;
	// that store may be retiring in the same cycle
	assign youngestLeaving = commitSt_i && (youngestSt == stqHead_i);

	always_ff @(posedge clk)
	begin
		if (ldDispatch_i)
		begin
			lastSt[ldDispatchIdx_i] <= youngestSt;
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			lastStValid <= '0;
		end
		else if (recover_i)
		begin
			lastStValid <= '0;
		end
		else
		begin
			// drop records pointing at the committing store
			for (int i = 0; i < LdqDepth; i++)
			begin
				if (commitSt_i && (lastSt[i] == stqHead_i))
				begin
					lastStValid[i] <= 1'b0;
				end
			end
			if (ldDispatch_i)
			begin
				lastStValid[ldDispatchIdx_i] <= !stqEmpty_i && !youngestLeaving;
			end
		end
	end

	assign lastSt_o      = lastSt[ldLookupIdx_i];
	assign lastStValid_o = lastStValid[ldLookupIdx_i];

endmodule

//--- hdl/lsqPkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// load/store queue geometry
// and store entry layout
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package lsqPkg;
	import memOpPkg::*;

	localparam int StqDepth    = 8;
	localparam int LdqDepth    = 8;
	localparam int StqIdxWidth = $clog2(StqDepth);
	localparam int LdqIdxWidth = $clog2(LdqDepth);

	// tag array compare modes
	localparam int CamEqual   = 0;
	localparam int CamGreater = 1;

	typedef logic [StqIdxWidth-1:0] stqIdxT;
	typedef logic [LdqIdxWidth-1:0] ldqIdxT;
	// one extra bit so full and empty differ
	typedef logic [StqIdxWidth:0]   stqCountT;
	typedef logic [StqDepth-1:0]    stqVecT;

	// 66 bits of store payload
	typedef struct packed {
		dataT       data;
		addrT       addr;
		accessSizeT size;
	} stqEntryT;

endpackage

//--- hdl/memOpPkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory access definitions
// widths, access sizes, bus select
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package memOpPkg;

	localparam int DataWidth   = 32;
	localparam int AddrWidth   = 32;
	localparam int OffsetWidth = 2;
	// one select bit per data byte
	localparam int SelWidth    = DataWidth / 8;

	typedef logic [DataWidth-1:0]             dataT;
	typedef logic [AddrWidth-1:0]             addrT;
	typedef logic [OffsetWidth-1:0]           offsetT;
	typedef logic [AddrWidth-OffsetWidth-1:0] wordAddrT;
	typedef logic [SelWidth-1:0]              selT;

	// numeric order follows access width
	typedef enum logic [1:0] {
		SizeByte = 2'd0,
		SizeHalf = 2'd1,
		SizeWord = 2'd2
	} accessSizeT;

	// keep only the low bytes covered by the access
	function automatic dataT zeroExtend(input dataT value, input accessSizeT size);
		case (size)
			SizeByte: return dataT'(value[7:0]);
			SizeHalf: return dataT'(value[15:0]);
			default:  return value;
		endcase
	endfunction

endpackage

//--- hdl/storeQueue.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// store queue
// allocation, agen capture, commit read-out
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module storeQueue
	import memOpPkg::*, lsqPkg::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       recover_i,
	input  logic       stDispatch_i,
	input  logic       stAgenValid_i,
	input  stqIdxT     stAgenIdx_i,
	input  addrT       stAgenAddr_i,
	input  dataT       stAgenData_i,
	input  accessSizeT stAgenSize_i,
	input  logic       commitSt_i,
	stqSearchIf.store  search,
	output stqIdxT     tail_o,
	output logic       empty_o,
	output logic       full_o,
	output logic       stCommitValid_o,
	output addrT       stCommitAddr_o,
	output dataT       stCommitData_o,
	output accessSizeT stCommitSize_o
);

	stqIdxT     head;
	stqIdxT     tail;
	stqCountT   count;
	stqVecT     addrValid;
	stqEntryT   entries [StqDepth];
	stqEntryT   headEntry;
	accessSizeT sizeTag;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			head      <= '0;
			tail      <= '0;
			count     <= '0;
			addrValid <= '0;
		end
		else if (recover_i)
		begin
			// flush everything not yet committed
			tail      <= head;
			count     <= '0;
			addrValid <= '0;
		end
		else
		begin
			if (stDispatch_i)
			begin
				tail <= tail + 1'b1;
			end
			if (commitSt_i)
			begin
				head            <= head + 1'b1;
				addrValid[head] <= 1'b0;
			end
			if (stAgenValid_i)
			begin
				addrValid[stAgenIdx_i] <= 1'b1;
			end
			case ({stDispatch_i, commitSt_i})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// payload written at address generation
	always_ff @(posedge clk)
	begin
		if (stAgenValid_i)
		begin
			entries[stAgenIdx_i] <= '{data: stAgenData_i, addr: stAgenAddr_i,
			                         size: stAgenSize_i};
		end
	end

	stqCam #(.tagT(wordAddrT), .Mode(CamEqual)) wordCam (
		.clk         (clk),
		.we_i        (stAgenValid_i),
		.wrIdx_i     (stAgenIdx_i),
		.wrTag_i     (stAgenAddr_i[AddrWidth-1:OffsetWidth]),
		.searchTag_i (search.wordAddr),
		.match_o     (search.wordMatch)
	);

	stqCam #(.tagT(offsetT), .Mode(CamEqual)) offsetCam (
		.clk         (clk),
		.we_i        (stAgenValid_i),
		.wrIdx_i     (stAgenIdx_i),
		.wrTag_i     (stAgenAddr_i[OffsetWidth-1:0]),
		.searchTag_i (search.offset),
		.match_o     (search.offsetMatch)
	);

	// size kept one step up, so greater-than means the store is not smaller
	assign sizeTag = accessSizeT'(stAgenSize_i + 2'd1);

	stqCam #(.tagT(accessSizeT), .Mode(CamGreater)) sizeCam (
		.clk         (clk),
		.we_i        (stAgenValid_i),
		.wrIdx_i     (stAgenIdx_i),
		.wrTag_i     (sizeTag),
		.searchTag_i (search.size),
		.match_o     (search.sizeGreater)
	);

	// second read port for the forwarding pick
	assign search.fwdEntry  = entries[search.fwdIdx];
	assign search.addrValid = addrValid;
	assign search.head      = head;

	assign tail_o  = tail;
	assign empty_o = (count == '0);
	assign full_o  = (count == stqCountT'(StqDepth));

	// head entry shown once its address is known
	assign headEntry       = entries[head];
	assign stCommitValid_o = !empty_o && addrValid[head];
	assign stCommitAddr_o  = headEntry.addr;
	assign stCommitData_o  = headEntry.data;
	assign stCommitSize_o  = headEntry.size;

	commitOnlyReady: assert property (@(posedge clk) disable iff (reset)
		commitSt_i |-> stCommitValid_o);

	noDispatchWhenFull: assert property (@(posedge clk) disable iff (reset)
		stDispatch_i |-> !full_o);

endmodule

//--- hdl/stqCam.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// store queue tag array
// one write port, match vector out
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module stqCam
	import lsqPkg::*;
#(
	parameter type tagT = logic,
	parameter int  Mode = CamEqual
) (
	input  logic   clk,
	input  logic   we_i,
	input  stqIdxT wrIdx_i,
	input  tagT    wrTag_i,
	input  tagT    searchTag_i,
	output stqVecT match_o
);

	// one tag per store entry
	tagT tags [StqDepth];

	always_ff @(posedge clk)
	begin
		if (we_i)
		begin
			tags[wrIdx_i] <= wrTag_i;
		end
	end

	// every entry compared in parallel
	always_comb
	begin
		for (int i = 0; i < StqDepth; i++)
		begin
			if (Mode == CamGreater)
			begin
				match_o[i] = (tags[i] > searchTag_i);
			end
			else
			begin
				match_o[i] = (tags[i] == searchTag_i);
			end
		end
	end

endmodule

//--- hdl/stqSearchIf.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// store queue search port
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface stqSearchIf
	import memOpPkg::*, lsqPkg::*;
();

	// load under disambiguation
	wordAddrT   wordAddr;
	offsetT     offset;
	accessSizeT size;
	// entry picked for forwarding
	stqIdxT     fwdIdx;

	// per-entry answers, same cycle
	stqVecT     wordMatch;
	stqVecT     offsetMatch;
	// set where the store is at least as wide as the load
	stqVecT     sizeGreater;
	stqVecT     addrValid;
	stqIdxT     head;
	stqEntryT   fwdEntry;

	modport searcher (
		output wordAddr, offset, size, fwdIdx,
		input  wordMatch, offsetMatch, sizeGreater, addrValid, head, fwdEntry
	);

	modport store (
		input  wordAddr, offset, size, fwdIdx,
		output wordMatch, offsetMatch, sizeGreater, addrValid, head, fwdEntry
	);

endinterface

//--- src.f
hdl/memOpPkg.sv
hdl/lsqPkg.sv
hdl/stqSearchIf.sv
hdl/stqCam.sv
hdl/storeQueue.sv
hdl/loadQueue.sv
hdl/loadDisambig.sv
hdl/loadMemPort.sv
hdl/ldxPath.sv
dv/tb_ldxPath.sv
